// ==== include/bch_sc_cfg.svh ====
`ifndef BCH_SC_CFG_SVH
`define BCH_SC_CFG_SVH

// field order GF(2^4)
`define SC_GF_M 4

// code block width and counts
`define SC_P_LVL 3
`define SC_N_BLK 5
`define SC_MSG_BLK 3 // message blocks incl. 2 check bits
`define SC_ADDR_W 2

// minimal polynomials with bit 4 as x^4
`define SC_POLY_M1 5'b10011 // x^4+x+1 is also the field polynomial
`define SC_POLY_M3 5'b11111 // x^4+x^3+x^2+x+1

`endif

// ==== design/gf_pkg.sv ====
`include "bch_sc_cfg.svh"

package gf_pkg;

    typedef logic [`SC_GF_M-1:0] gf_elem_t;

    // low part of the field polynomial
    localparam gf_elem_t GF_POLY_LOW = gf_elem_t'(`SC_POLY_M1);

    // a * alpha reduced mod x^4+x+1
    function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
        gf_elem_t res;
        res = {a[`SC_GF_M-2:0], 1'b0};
        if (a[`SC_GF_M-1]) begin
            res = res ^ GF_POLY_LOW;
        end
        return res;
    endfunction

    // a * alpha^pwr
    function automatic gf_elem_t gf_mul_alpha_pow(input gf_elem_t a, input int unsigned pwr);
        gf_elem_t res;
        res = a;
        for (int k = 0; k < pwr; k++) begin
            res = gf_mul_alpha(res);
        end
        return res;
    endfunction

    // remainder polynomial evaluated at alpha^pwr
    // coefficients are binary so each Horner step adds 0 or 1
    function automatic gf_elem_t gf_eval(input gf_elem_t rem, input int unsigned pwr);
        gf_elem_t acc;
        acc = '0;
        for (int i = `SC_GF_M-1; i >= 0; i--) begin
            acc = gf_mul_alpha_pow(acc, pwr);
            acc[0] = acc[0] ^ rem[i];
        end
        return acc;
    endfunction

    // nonzero test for the error flag
    function automatic logic gf_is_nonzero(input gf_elem_t a);
        return |a;
    endfunction

endpackage

// ==== design/sc_pkg.sv ====
`include "bch_sc_cfg.svh"

package sc_pkg;

    import gf_pkg::*;

    typedef enum logic [7:0] {
        IDLE     = 8'b0000_0001,
        START_WR = 8'b0000_0010, // first block with buffer write
        FEED_WR  = 8'b0000_0100,
        FEED     = 8'b0000_1000, // check blocks without write
        PAUSE_WR = 8'b0001_0000,
        PAUSE    = 8'b0010_0000,
        EVAL     = 8'b0100_0000,
        OUT      = 8'b1000_0000
    } sc_state_e;

    // control to dividers and evaluator
    typedef struct packed {
        logic [`SC_P_LVL-1:0] blk;
        logic                 clr;
        logic                 fold;
        logic                 eval;
    } sc_step_t;

    typedef struct packed {
        logic                  en;
        logic [`SC_ADDR_W-1:0] addr;
        logic [`SC_P_LVL-1:0]  data;
    } sc_wr_t;

    typedef struct packed {
        gf_elem_t s1;
        gf_elem_t s2;
        gf_elem_t s3;
        gf_elem_t s4;
    } sc_synd_t;

endpackage

// ==== design/sc_ctrl.sv ====
`include "bch_sc_cfg.svh"
`timescale 1ns/1ps

module sc_ctrl
    import sc_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_RESET,
    input  logic                 i_stop_dec,
    input  logic                 i_exe_sc,
    input  logic                 i_code_valid,
    input  logic [`SC_P_LVL-1:0] i_code,
    input  logic                 i_buf_available,
    output sc_step_t             o_step,
    output sc_wr_t               o_wr,
    output logic                 o_sc_available,
    output logic                 o_sc_start,
    output logic                 o_sc_cmplt
);

    localparam int CNT_W = $clog2(`SC_N_BLK);

    sc_state_e r_state;
    sc_state_e r_nxt;

    logic [CNT_W-1:0]     r_cnt; // blocks folded so far
    logic [`SC_P_LVL-1:0] r_blk;
    logic                 r_wr_en;

    logic w_wr_done;
    logic w_div_done;
    logic w_accept;

    assign w_wr_done  = (r_cnt == CNT_W'(`SC_MSG_BLK - 1));
    assign w_div_done = (r_cnt == CNT_W'(`SC_N_BLK - 1));
    assign w_accept   = (r_nxt == START_WR) || (r_nxt == FEED_WR) || (r_nxt == FEED);

    always_ff @(posedge i_clk) begin
        if (i_RESET || i_stop_dec) begin
            r_state <= IDLE;
        end else begin
            r_state <= r_nxt;
        end
    end

    always_comb begin
        unique case (r_state)
            IDLE:     r_nxt = (i_exe_sc && i_code_valid) ? START_WR : IDLE;
            START_WR: r_nxt = i_code_valid ? FEED_WR : PAUSE_WR;
            FEED_WR: begin
                if (i_code_valid) begin
                    r_nxt = w_wr_done ? FEED : FEED_WR;
                end else begin
                    r_nxt = w_wr_done ? PAUSE : PAUSE_WR;
                end
            end
            FEED: begin
                if (w_div_done) begin
                    r_nxt = EVAL; // last block already registered
                end else begin
                    r_nxt = i_code_valid ? FEED : PAUSE;
                end
            end
            PAUSE_WR: r_nxt = i_code_valid ? FEED_WR : PAUSE_WR;
            PAUSE:    r_nxt = i_code_valid ? FEED : PAUSE;
            EVAL:     r_nxt = OUT;
            OUT:      r_nxt = i_buf_available ? IDLE : OUT;
            default:  r_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_RESET || i_stop_dec) begin
            r_cnt   <= '0;
            r_wr_en <= 1'b0;
        end else begin
            r_wr_en <= (r_nxt == START_WR) || (r_nxt == FEED_WR);
            case (r_nxt)
                START_WR:      r_cnt <= '0;
                FEED_WR, FEED: r_cnt <= r_cnt + 1'b1;
                PAUSE_WR, PAUSE: r_cnt <= r_cnt; // hold through the gap
                default:       r_cnt <= '0;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_blk <= i_code;
        end
    end

    // previous block is folded while the new one is registered
    assign o_step = '{
        blk:  r_blk,
        clr:  (r_nxt == START_WR),
        fold: (r_nxt == FEED_WR) || (r_nxt == FEED) || (r_nxt == EVAL),
        eval: (r_nxt == EVAL)
    };

    assign o_wr = '{en: r_wr_en, addr: r_cnt[`SC_ADDR_W-1:0], data: r_blk};

    assign o_sc_available = (r_state == IDLE);
    assign o_sc_start     = (r_state == START_WR);
    assign o_sc_cmplt     = (r_state == OUT) && i_buf_available;

endmodule

// ==== design/sc_lfs_divider.sv ====
`include "bch_sc_cfg.svh"
`timescale 1ns/1ps

module sc_lfs_divider
    import gf_pkg::*;
    import sc_pkg::*;
#(
    parameter logic [`SC_GF_M:0] POLY = `SC_POLY_M1
) (
    input  logic     i_clk,
    input  logic     i_RESET,
    input  logic     i_stop_dec,
    input  sc_step_t i_step,
    output gf_elem_t o_rem
);

    gf_elem_t r_rem;
    gf_elem_t w_nxt_rem;

    // one division step per block bit starting at the msb
    always_comb begin : fold_blk
        logic fb;
        w_nxt_rem = r_rem;
        for (int b = `SC_P_LVL-1; b >= 0; b--) begin
            fb = w_nxt_rem[`SC_GF_M-1];
            w_nxt_rem = {w_nxt_rem[`SC_GF_M-2:0], i_step.blk[b]};
            if (fb) begin
                w_nxt_rem = w_nxt_rem ^ POLY[`SC_GF_M-1:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_RESET || i_stop_dec || i_step.clr) begin
            r_rem <= '0;
        end else if (i_step.fold) begin
            r_rem <= w_nxt_rem;
        end
    end

    assign o_rem = r_rem;

endmodule

// ==== design/sc_syndrome_out.sv ====
`timescale 1ns/1ps

module sc_syndrome_out
    import gf_pkg::*;
    import sc_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_RESET,
    input  logic     i_stop_dec,
    input  sc_step_t i_step,
    input  gf_elem_t i_rem1,
    input  gf_elem_t i_rem3,
    output sc_synd_t o_synd,
    output logic     o_error_detected
);

    sc_synd_t w_synd;
    logic     w_err;
    logic     r_eval_d; // remainders final one cycle after EVAL

    // alpha^2 and alpha^4 are conjugates of alpha and share m1
    always_comb begin
        w_synd.s1 = gf_eval(i_rem1, 1);
        w_synd.s2 = gf_eval(i_rem1, 2);
        w_synd.s3 = gf_eval(i_rem3, 3);
        w_synd.s4 = gf_eval(i_rem1, 4);
    end

    assign w_err = gf_is_nonzero(w_synd.s1) || gf_is_nonzero(w_synd.s3);

    always_ff @(posedge i_clk) begin
        if (i_RESET || i_stop_dec) begin
            r_eval_d <= 1'b0;
        end else begin
            r_eval_d <= i_step.eval;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_RESET || i_stop_dec || i_step.clr) begin
            o_synd           <= '0;
            o_error_detected <= 1'b0;
        end else if (r_eval_d) begin
            o_synd           <= w_synd;
            o_error_detected <= w_err;
        end
    end

endmodule

// ==== design/bch_sc_top.sv ====
`include "bch_sc_cfg.svh"
`timescale 1ns/1ps

module bch_sc_top
    import gf_pkg::*;
    import sc_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_RESET,
    input  logic                 i_stop_dec,
    input  logic                 i_exe_sc,
    input  logic                 i_code_valid,
    input  logic [`SC_P_LVL-1:0] i_code,
    input  logic                 i_buf_available,
    output logic                 o_sc_available,
    output logic                 o_sc_start,
    output logic                 o_sc_cmplt,
    output logic                 o_error_detected,
    output sc_wr_t               o_wr,
    output sc_synd_t             o_synd
);

    sc_step_t w_step;
    gf_elem_t w_rem1;
    gf_elem_t w_rem3;

    sc_ctrl ctrl_i (
        .i_clk           (i_clk),
        .i_RESET         (i_RESET),
        .i_stop_dec      (i_stop_dec),
        .i_exe_sc        (i_exe_sc),
        .i_code_valid    (i_code_valid),
        .i_code          (i_code),
        .i_buf_available (i_buf_available),
        .o_step          (w_step),
        .o_wr            (o_wr),
        .o_sc_available  (o_sc_available),
        .o_sc_start      (o_sc_start),
        .o_sc_cmplt      (o_sc_cmplt)
    );

    sc_lfs_divider #(.POLY(`SC_POLY_M1)) div_m1_i (
        .i_clk      (i_clk),
        .i_RESET    (i_RESET),
        .i_stop_dec (i_stop_dec),
        .i_step     (w_step),
        .o_rem      (w_rem1)
    );

    sc_lfs_divider #(.POLY(`SC_POLY_M3)) div_m3_i (
        .i_clk      (i_clk),
        .i_RESET    (i_RESET),
        .i_stop_dec (i_stop_dec),
        .i_step     (w_step),
        .o_rem      (w_rem3)
    );

    sc_syndrome_out synd_out_i (
        .i_clk            (i_clk),
        .i_RESET          (i_RESET),
        .i_stop_dec       (i_stop_dec),
        .i_step           (w_step),
        .i_rem1           (w_rem1),
        .i_rem3           (w_rem3),
        .o_synd           (o_synd),
        .o_error_detected (o_error_detected)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk; // 4 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== bench/bch_sc_chk.sv ====
`timescale 1ns/1ps

module bch_sc_chk
    import sc_pkg::*;
(
    input logic   i_clk,
    input logic   i_RESET,
    input logic   o_sc_start,
    input logic   o_sc_cmplt,
    input sc_wr_t o_wr
);

    int unsigned n_fail = 0; // failures seen so far

    // start and completion belong to different phases
    start_cmplt_excl: assert property (
        @(posedge i_clk) disable iff (i_RESET) !(o_sc_start && o_sc_cmplt)
    ) else begin
        $error("o_sc_start and o_sc_cmplt high in the same cycle");
        n_fail++;
    end

    cmplt_pulse: assert property (
        @(posedge i_clk) disable iff (i_RESET) o_sc_cmplt |=> !o_sc_cmplt
    ) else begin
        $error("o_sc_cmplt high for more than one cycle");
        n_fail++;
    end

    start_writes_first: assert property (
        @(posedge i_clk) disable iff (i_RESET) o_sc_start |-> (o_wr.en && o_wr.addr == '0)
    ) else begin
        $error("no buffer write to address 0 in the start cycle");
        n_fail++;
    end

endmodule

// ==== bench/bch_sc_tb.sv ====
`include "bch_sc_cfg.svh"
`timescale 1ns/1ps

module bch_sc_tb
    import sc_pkg::*;
();

    localparam int N_ENT = 10;
    localparam int CYC_LIMIT = 40 * N_ENT + 50;
    localparam logic [4:0] FIELD_POLY = `SC_POLY_M1;
    localparam logic [8:0] GEN_POLY = 9'h1d1; // m1 * m3

    typedef struct packed {
        logic [14:0] cw;
        logic [3:0]  pause; // bit b gives a gap after block b
        logic [3:0]  stall; // cycles with the buffer busy
        logic        valid_cw;
        logic        abort;
        sc_synd_t    exp_synd;
        logic        exp_err;
    } entry_t;

    logic                 i_clk;
    logic                 i_RESET;
    logic                 i_stop_dec;
    logic                 i_exe_sc;
    logic                 i_code_valid;
    logic [`SC_P_LVL-1:0] i_code;
    logic                 i_buf_available;
    logic                 o_sc_available;
    logic                 o_sc_start;
    logic                 o_sc_cmplt;
    logic                 o_error_detected;
    sc_wr_t               o_wr;
    sc_synd_t             o_synd;

    entry_t      tbl [N_ENT];
    logic [1:0]  wr_addr_q [$];
    logic [2:0]  wr_data_q [$];
    int unsigned start_cnt = 0;
    int unsigned cyc = 0;

    tb_clk_gen clk_gen_i (.o_clk(i_clk), .o_rst(i_RESET));

    bch_sc_top dut_i (.*);

    bind bch_sc_top bch_sc_chk chk_i (.*);

    function automatic logic [3:0] alpha_to(input int unsigned k);
        logic [3:0] e;
        e = 4'b0001;
        for (int n = 0; n < k % 15; n++) begin
            e = e[3] ? ({e[2:0], 1'b0} ^ FIELD_POLY[3:0]) : {e[2:0], 1'b0};
        end
        return e;
    endfunction

    // S_j = sum of alpha^(i*j) over the set bits i
    function automatic logic [3:0] synd_ref(input logic [14:0] cw, input int unsigned j);
        logic [3:0] s;
        s = '0;
        for (int i = 0; i < 15; i++) begin
            if (cw[i]) begin
                s = s ^ alpha_to(i * j);
            end
        end
        return s;
    endfunction

    function automatic logic [14:0] encode(input logic [6:0] msg);
        logic [14:0] cw;
        cw = '0;
        for (int i = 0; i < 7; i++) begin
            if (msg[i]) begin
                cw = cw ^ (15'(GEN_POLY) << i);
            end
        end
        return cw;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic entry_t make_entry(input logic [14:0] cw, input logic [3:0] pause,
                                          input logic [3:0] stall, input logic valid_cw,
                                          input logic abort);
        entry_t e;
        e.cw          = cw;
        e.pause       = pause;
        e.stall       = stall;
        e.valid_cw    = valid_cw;
        e.abort       = abort;
        e.exp_synd.s1 = synd_ref(cw, 1);
        e.exp_synd.s2 = synd_ref(cw, 2);
        e.exp_synd.s3 = synd_ref(cw, 3);
        e.exp_synd.s4 = synd_ref(cw, 4);
        e.exp_err     = (e.exp_synd.s1 != '0) || (e.exp_synd.s3 != '0);
        return e;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // blocks go msb first with one per accepted cycle
    task automatic send_blocks(input entry_t e, input int n_blk);
        @(posedge i_clk);
        wr_addr_q.delete();
        wr_data_q.delete();
        start_cnt = 0;
        i_buf_available <= (e.stall == 0);
        for (int b = 0; b < n_blk; b++) begin
            if (b > 0) begin
                @(posedge i_clk);
            end
            i_exe_sc     <= (b == 0);
            i_code_valid <= 1'b1;
            i_code       <= e.cw[14 - 3*b -: 3];
            if ((b < n_blk - 1) && e.pause[b]) begin
                @(posedge i_clk);
                i_exe_sc     <= 1'b0;
                i_code_valid <= 1'b0;
            end
        end
        @(posedge i_clk);
        i_exe_sc     <= 1'b0;
        i_code_valid <= 1'b0;
    endtask

    task automatic finish_word(input entry_t e);
        sc_synd_t held;
        repeat (2) @(posedge i_clk); // EVAL then OUT
        if (e.stall != 0) begin
            @(negedge i_clk);
            held = o_synd;
            repeat (e.stall) begin
                @(negedge i_clk);
                assert (!o_sc_cmplt && !o_sc_available && o_synd == held)
                else report_error("outputs changed while the buffer was busy");
            end
            @(posedge i_clk);
            i_buf_available <= 1'b1;
        end
        do begin
            @(negedge i_clk);
        end while (!o_sc_cmplt);
        assert (o_synd == e.exp_synd)
        else report_error($sformatf("syndromes %h, expected %h", o_synd, e.exp_synd));
        assert (o_error_detected == e.exp_err)
        else report_error($sformatf("error flag %b, expected %b", o_error_detected, e.exp_err));
        assert (!e.valid_cw || (o_synd == '0 && !o_error_detected))
        else report_error("valid codeword gave nonzero syndromes");
        assert (start_cnt == 1)
        else report_error($sformatf("%0d start pulses, expected 1", start_cnt));
        assert (wr_addr_q.size() == `SC_MSG_BLK)
        else report_error($sformatf("%0d buffer writes, expected 3", wr_addr_q.size()));
        for (int k = 0; k < `SC_MSG_BLK; k++) begin
            assert (wr_addr_q[k] == k && wr_data_q[k] == e.cw[14 - 3*k -: 3])
            else report_error($sformatf("write %0d: addr %0d data %b", k, wr_addr_q[k],
                                        wr_data_q[k]));
        end
        @(negedge i_clk);
        assert (!o_sc_cmplt && o_sc_available)
        else report_error("DUT not idle after the completion pulse");
    endtask

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    always @(negedge i_clk) begin
        if (!i_RESET && o_wr.en) begin
            wr_addr_q.push_back(o_wr.addr);
            wr_data_q.push_back(o_wr.data);
        end
        if (!i_RESET && o_sc_start) begin
            start_cnt++;
        end
        assert (dut_i.chk_i.n_fail == 0)
        else report_error("a bound assertion on the DUT failed");
    end

    initial begin
        logic [31:0] rnd;
        i_stop_dec      = 1'b0;
        i_exe_sc        = 1'b0;
        i_code_valid    = 1'b0;
        i_code          = '0;
        i_buf_available = 1'b1;
        rnd = 32'h451d;
        tbl[0] = make_entry(encode(7'h00), 4'b0000, 4'd0, 1'b1, 1'b0);
        tbl[1] = make_entry(encode(7'h5b), 4'b0101, 4'd3, 1'b1, 1'b0);
        tbl[2] = make_entry(encode(7'h7f), 4'b1111, 4'd0, 1'b1, 1'b0);
        tbl[3] = make_entry(encode(7'h12) ^ 15'h4000, 4'b0000, 4'd2, 1'b0, 1'b0);
        tbl[4] = make_entry(encode(7'h33) ^ 15'h0001, 4'b0010, 4'd0, 1'b0, 1'b0);
        tbl[5] = make_entry(encode(7'h61) ^ 15'h0408, 4'b1001, 4'd5, 1'b0, 1'b0);
        tbl[6] = make_entry(encode(7'h2a) ^ 15'h0080, 4'b0100, 4'd1, 1'b0, 1'b1);
        for (int k = 7; k < N_ENT; k++) begin
            rnd = xorshift32(rnd);
            tbl[k] = make_entry(rnd[14:0], rnd[19:16], {1'b0, rnd[22:20]}, 1'b0, 1'b0);
        end
        @(negedge i_RESET);
        @(negedge i_clk);
        assert (o_sc_available && !o_sc_start && !o_sc_cmplt && !o_error_detected &&
                !o_wr.en && o_synd == '0)
        else report_error("outputs after reset are wrong");
        for (int k = 0; k < N_ENT; k++) begin
            if (tbl[k].abort) begin
                send_blocks(tbl[k], 3); // abort in the middle of the word
                i_stop_dec <= 1'b1;
                @(posedge i_clk);
                i_stop_dec <= 1'b0;
                @(negedge i_clk);
                assert (o_sc_available && o_synd == '0 && !o_error_detected && !o_wr.en)
                else report_error("i_stop_dec did not return the DUT to idle");
            end
            send_blocks(tbl[k], `SC_N_BLK);
            finish_word(tbl[k]);
        end
        repeat (2) @(negedge i_clk);
        if (dut_i.chk_i.n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bch_sc.f ====
+incdir+include
design/gf_pkg.sv
design/sc_pkg.sv
design/sc_ctrl.sv
design/sc_lfs_divider.sv
design/sc_syndrome_out.sv
design/bch_sc_top.sv
bench/tb_clk_gen.sv
bench/bch_sc_chk.sv
bench/bch_sc_tb.sv
